// ==== verilog/xbus_settings.svh ====
// ====================
// xbus sizing and timing macros
// address map limits, RAM size,
// RAM ack delay, bus timeout
// ====================
`ifndef XBUS_SETTINGS_SVH
`define XBUS_SETTINGS_SVH

// bus address width in words
`define XBUS_ADDR_BITS 22

// backed RAM, cut down for simulation
`define XBUS_DRAM_BITS 10
`define XBUS_DRAM_SIZE 1024

// RAM decodes everything below this
`define XBUS_DRAM_LIMIT (22'o11000000)

// base of the 8-word I/O register block
`define XBUS_IO_BASE (22'o17772000)

// RAM ack chain depth, ack comes from stage 1
`define XBUS_ACK_DELAY 7

// cycles before an undecoded request is failed
`define XBUS_TIMEOUT 16

`endif

// ==== verilog/xbus_pkg.sv ====
// ====================
// xbus request and response structs
// ====================
`include "xbus_settings.svh"

package xbus_pkg;

   // master side of the bus
   // addr, data and write are held stable while req is high
   typedef struct packed {
      logic [`XBUS_ADDR_BITS-1:0] addr;
      logic [31:0]                data;
      logic                       write;
      logic                       req;
   } xbus_req_t;

   // slave side of the bus
   // decode is address based, ack is a single cycle pulse
   // read data is valid while ack is high
   typedef struct packed {
      logic [31:0] data;
      logic        ack;
      logic        decode;
   } xbus_rsp_t;

endpackage

// ==== verilog/xbus_map_pkg.sv ====
// ====================
// xbus address map types
// slave select, I/O register offsets,
// response combiner states
// ====================

package xbus_map_pkg;

   // which slave claims the current address
   typedef enum logic [1:0] {
      SEL_NONE = 2'd0,
      SEL_RAM  = 2'd1,
      SEL_IO   = 2'd2
   } slave_sel_e;

   // word offsets inside the I/O block
   // offsets 6 and 7 read zero and drop writes
   typedef enum logic [2:0] {
      IO_SCRATCH0    = 3'd0,
      IO_SCRATCH1    = 3'd1,
      IO_SCRATCH2    = 3'd2,
      IO_SCRATCH3    = 3'd3,
      IO_WRITE_COUNT = 3'd4,
      IO_ID          = 3'd5,
      IO_RSVD6       = 3'd6,
      IO_RSVD7       = 3'd7
   } io_reg_e;

   // timeout machine for undecoded accesses
   typedef enum logic [1:0] {
      RS_IDLE  = 2'd0,
      RS_WAIT  = 2'd1,
      RS_ERROR = 2'd2
   } resp_state_e;

endpackage

// ==== verilog/xbus_ram.sv ====
// ====================
// xbus RAM slave
// decode below the RAM limit, delayed ack chain,
// all ones beyond the backed words
// ====================
`timescale 1ns/1ps
`include "xbus_settings.svh"

module xbus_ram
   import xbus_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  xbus_req_t bus_req,
   output xbus_rsp_t bus_rsp
);

   logic [31:0]                ram [`XBUS_DRAM_SIZE];
   logic [`XBUS_DRAM_BITS-1:0] word_index;
   logic                       decode;
   logic                       backed;
   logic                       accept;
   logic                       req_delayed;
   logic [`XBUS_ACK_DELAY-1:0] ack_chain;

   // contents start cleared
   initial
   begin
      for (int i = 0; i < `XBUS_DRAM_SIZE; i++)
      begin
         ram[i] = '0;
      end
   end

   // the top of the decoded space has no storage behind it
   assign decode     = bus_req.addr < `XBUS_DRAM_LIMIT;
   assign backed     = bus_req.addr < `XBUS_DRAM_SIZE;
   assign word_index = bus_req.addr[`XBUS_DRAM_BITS-1:0];

   // one acceptance per request then busy until the chain drains
   assign accept = bus_req.req && decode && !req_delayed && (ack_chain == '0);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         req_delayed <= 1'b0;
         ack_chain   <= '0;
      end
      else
      begin
         req_delayed <= accept;
         ack_chain   <= {ack_chain[`XBUS_ACK_DELAY-2:0], req_delayed};
      end
   end

   // write lands at acceptance and is dropped above storage
   always_ff @(posedge clk)
   begin
      if (accept && bus_req.write && backed)
      begin
         ram[word_index] <= bus_req.data;
      end
   end

   assign bus_rsp.data   = backed ? ram[word_index] : '1;
   assign bus_rsp.ack    = ack_chain[1];
   assign bus_rsp.decode = decode;

   // ack only ever follows an accepted request
   ack_after_accept: assert property (@(posedge clk) disable iff (reset)
      $rose(bus_rsp.ack) |-> $past(accept, 3));

endmodule

// ==== verilog/xbus_io_regs.sv ====
// ====================
// xbus I/O register slave
// four scratch words, write counter, id word
// ====================
`timescale 1ns/1ps
`include "xbus_settings.svh"

module xbus_io_regs
   import xbus_pkg::*;
   import xbus_map_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  xbus_req_t bus_req,
   output xbus_rsp_t bus_rsp
);

   localparam logic [`XBUS_ADDR_BITS-1:0] io_base = `XBUS_IO_BASE;
   localparam logic [31:0]                io_id   = 32'hc0de_0001;

   logic [31:0] scratch [4];
   logic [31:0] write_count;
   logic [31:0] read_data;
   logic        decode;
   logic        accept;
   logic        ack_q;
   io_reg_e     reg_sel;

   // eight words, so the low three bits pick the register
   assign decode  = bus_req.addr[`XBUS_ADDR_BITS-1:3] == io_base[`XBUS_ADDR_BITS-1:3];
   assign reg_sel = io_reg_e'(bus_req.addr[2:0]);

   // no accept in the ack cycle while the master still holds req
   assign accept = bus_req.req && decode && !ack_q;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ack_q       <= 1'b0;
         write_count <= '0;
         for (int i = 0; i < 4; i++)
         begin
            scratch[i] <= '0;
         end
      end
      else
      begin
         ack_q <= accept;
         if (accept && bus_req.write)
         begin
            // every write counts, even to read-only offsets
            write_count <= write_count + 32'd1;
            case (reg_sel)
               IO_SCRATCH0, IO_SCRATCH1, IO_SCRATCH2, IO_SCRATCH3:
                  scratch[bus_req.addr[1:0]] <= bus_req.data;
               default:
                  ;
            endcase
         end
      end
   end

   always_comb
   begin
      case (reg_sel)
         IO_SCRATCH0, IO_SCRATCH1, IO_SCRATCH2, IO_SCRATCH3:
            read_data = scratch[bus_req.addr[1:0]];
         IO_WRITE_COUNT:
            read_data = write_count;
         IO_ID:
            read_data = io_id;
         default:
            read_data = '0;
      endcase
   end

   assign bus_rsp.data   = read_data;
   assign bus_rsp.ack    = ack_q;
   assign bus_rsp.decode = decode;

   // single cycle ack pulse
   ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
      bus_rsp.ack |=> !bus_rsp.ack);

endmodule

// ==== verilog/xbus_response_mux.sv ====
// ====================
// xbus response combiner
// slave select, ack and data steering,
// timeout to bus error for undecoded requests
// ====================
`timescale 1ns/1ps
`include "xbus_settings.svh"

module xbus_response_mux
   import xbus_pkg::*;
   import xbus_map_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  xbus_req_t   bus_req,
   input  xbus_rsp_t   ram_rsp,
   input  xbus_rsp_t   io_rsp,
   output logic [31:0] dataout,
   output logic        ack,
   output logic        bus_error
);

   localparam int timeout_w = $clog2(`XBUS_TIMEOUT);
   localparam logic [timeout_w-1:0] timeout_last = timeout_w'(`XBUS_TIMEOUT - 1);

   slave_sel_e           sel;
   resp_state_e          state;
   logic [timeout_w-1:0] timeout_count;

   always_comb
   begin
      case ({io_rsp.decode, ram_rsp.decode})
         2'b01:   sel = SEL_RAM;
         2'b10:   sel = SEL_IO;
         default: sel = SEL_NONE;
      endcase
   end

   // waits out the timeout, then one error cycle
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state         <= RS_IDLE;
         timeout_count <= '0;
      end
      else
      begin
         case (state)
            RS_IDLE:
               if (bus_req.req && sel == SEL_NONE)
               begin
                  state         <= RS_WAIT;
                  timeout_count <= '0;
               end
            RS_WAIT:
               if (!bus_req.req || sel != SEL_NONE)
                  state <= RS_IDLE;
               else if (timeout_count == timeout_last)
                  state <= RS_ERROR;
               else
                  timeout_count <= timeout_count + 1'b1;
            RS_ERROR:
               state <= RS_IDLE;
            default:
               state <= RS_IDLE;
         endcase
      end
   end

   always_comb
   begin
      case (sel)
         SEL_RAM: dataout = ram_rsp.data;
         SEL_IO:  dataout = io_rsp.data;
         default: dataout = '1;
      endcase
   end

   assign bus_error = state == RS_ERROR;
   assign ack       = (sel == SEL_RAM && ram_rsp.ack) ||
                      (sel == SEL_IO && io_rsp.ack) || bus_error;

   // address map must not overlap
   decode_exclusive: assert property (@(posedge clk) disable iff (reset)
      !(ram_rsp.decode && io_rsp.decode));

endmodule

// ==== verilog/xbus_subsystem.sv ====
// ====================
// xbus memory subsystem top
// RAM slave, I/O slave, response combiner
// ====================
`timescale 1ns/1ps

module xbus_subsystem
   import xbus_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  xbus_req_t   bus_req,
   output logic [31:0] dataout,
   output logic        ack,
   output logic        bus_error
);

   xbus_rsp_t ram_rsp;
   xbus_rsp_t io_rsp;

   // both slaves see the same request
   xbus_ram ram_inst (
      .clk     (clk),
      .reset   (reset),
      .bus_req (bus_req),
      .bus_rsp (ram_rsp)
   );

   xbus_io_regs io_regs_inst (
      .clk     (clk),
      .reset   (reset),
      .bus_req (bus_req),
      .bus_rsp (io_rsp)
   );

   xbus_response_mux response_mux_inst (
      .clk       (clk),
      .reset     (reset),
      .bus_req   (bus_req),
      .ram_rsp   (ram_rsp),
      .io_rsp    (io_rsp),
      .dataout   (dataout),
      .ack       (ack),
      .bus_error (bus_error)
   );

endmodule

// ==== tests/xbus_subsystem_tb.sv ====
// ====================
// xbus subsystem testbench
// clock, reset, xorshift stimulus,
// watchdog and checking assertions
// ====================
`timescale 1ns/1ps
`include "xbus_settings.svh"

module xbus_subsystem_tb
   import xbus_pkg::*;
   import xbus_map_pkg::*;
();

   localparam logic [`XBUS_ADDR_BITS-1:0] io_base = `XBUS_IO_BASE;
   localparam int ram_count    = 24;
   localparam int beyond_count = 6;
   // RAM, beyond-storage, I/O and undecoded transactions
   localparam int num_txn = 2 * ram_count + 4 * beyond_count + 16 + 2;

   logic                       clk;
   logic                       reset;
   xbus_req_t                  bus_req;
   logic [31:0]                dataout;
   logic                       ack;
   logic                       bus_error;
   logic [31:0]                rng_state = 32'hfa5b;
   logic [31:0]                ram_shadow [`XBUS_DRAM_SIZE];
   logic [31:0]                scratch_shadow [4];
   logic [`XBUS_ADDR_BITS-1:0] ram_addrs [ram_count];
   logic [`XBUS_ADDR_BITS-1:0] addr;
   logic [31:0]                rdata;
   logic                       rsp_error;
   int                         latency;
   int                         io_writes;
   int                         ram_gap;

   wire ram_target = bus_req.addr < `XBUS_DRAM_LIMIT;
   wire io_target  = bus_req.addr[`XBUS_ADDR_BITS-1:3] == io_base[`XBUS_ADDR_BITS-1:3];

   xbus_subsystem xbus_subsystem_inst (
      .clk       (clk),
      .reset     (reset),
      .bus_req   (bus_req),
      .dataout   (dataout),
      .ack       (ack),
      .bus_error (bus_error)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic stop_on_error(input string line);
      $display("%s", line);
      $display("TEST FAIL");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected)
      else
         stop_on_error($sformatf("[ERROR] %s expected %h actual %h", name, expected, actual));
   endtask

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   function automatic logic [`XBUS_ADDR_BITS-1:0] io_addr(input io_reg_e r);
      return {io_base[`XBUS_ADDR_BITS-1:3], r};
   endfunction

   // held request, dropped at the edge where ack is seen
   task automatic bus_access(input logic [`XBUS_ADDR_BITS-1:0] a, input logic write,
                             input logic [31:0] data);
      @(posedge clk);
      bus_req <= '{addr: a, data: data, write: write, req: 1'b1};
      latency = 0;
      @(posedge clk);
      while (!ack)
      begin
         latency++;
         @(posedge clk);
      end
      rdata     = dataout;
      rsp_error = bus_error;
      bus_req.req <= 1'b0;
   endtask

   task automatic read_check(input string name, input logic [`XBUS_ADDR_BITS-1:0] a,
                             input logic [31:0] expected);
      bus_access(a, 1'b0, '0);
      check_value(name, expected, rdata);
   endtask

   // cycles since the last RAM ack, saturating
   always @(posedge clk)
   begin
      if (reset || (ack && ram_target))
         ram_gap <= 0;
      else if (ram_gap < 8)
         ram_gap <= ram_gap + 1;
   end

   ram_latency: assert property (@(posedge clk) disable iff (reset)
      $rose(bus_req.req) && ram_target && ram_gap >= 8 |-> !ack ##1 !ack ##1 !ack ##1 ack)
      else stop_on_error("[ERROR] ram_latency expected ack 3 edges after req, actual other");

   io_latency: assert property (@(posedge clk) disable iff (reset)
      $rose(bus_req.req) && io_target |-> !ack ##1 ack)
      else stop_on_error("[ERROR] io_latency expected ack 1 edge after req, actual other");

   // errors only for undecoded addresses, always with all-ones data
   error_undecoded: assert property (@(posedge clk) disable iff (reset)
      bus_error |-> ack && !ram_target && !io_target && dataout == '1)
      else stop_on_error("[ERROR] bus_error expected only on undecoded ack, actual elsewhere");

   initial
   begin
      repeat (num_txn * 40) @(posedge clk);
      stop_on_error("watchdog expired before all transactions finished");
   end

   initial
   begin
      reset   <= 1'b1;
      bus_req <= '0;
      io_writes = 0;
      for (int i = 0; i < `XBUS_DRAM_SIZE; i++)
         ram_shadow[i] = '0;
      repeat (3) @(posedge clk);
      reset <= 1'b0;

      for (int i = 0; i < ram_count; i++)
      begin
         rng_state = xorshift(rng_state);
         ram_addrs[i] = `XBUS_ADDR_BITS'(rng_state[`XBUS_DRAM_BITS-1:0]);
         rng_state = xorshift(rng_state);
         ram_shadow[ram_addrs[i][`XBUS_DRAM_BITS-1:0]] = rng_state;
         bus_access(ram_addrs[i], 1'b1, rng_state);
      end
      for (int i = 0; i < ram_count; i++)
      begin
         // idle now and then so the ack chain is empty
         if (i % 4 == 0)
            repeat (10) @(posedge clk);
         read_check("ram_readback", ram_addrs[i], ram_shadow[ram_addrs[i][`XBUS_DRAM_BITS-1:0]]);
      end

      // decoded but unbacked, writes must not alias into storage
      for (int i = 0; i < beyond_count; i++)
      begin
         rng_state = xorshift(rng_state);
         addr = `XBUS_ADDR_BITS'(`XBUS_DRAM_SIZE +
                rng_state % (`XBUS_DRAM_LIMIT - `XBUS_DRAM_SIZE));
         read_check("beyond_read", addr, '1);
         bus_access(addr, 1'b1, rng_state);
         read_check("beyond_after_write", addr, '1);
         read_check("beyond_alias", `XBUS_ADDR_BITS'(addr % `XBUS_DRAM_SIZE),
                    ram_shadow[addr[`XBUS_DRAM_BITS-1:0]]);
      end

      for (int i = 0; i < 4; i++)
      begin
         rng_state = xorshift(rng_state);
         scratch_shadow[i] = rng_state;
         bus_access(io_addr(io_reg_e'(i)), 1'b1, rng_state);
         io_writes++;
      end
      for (int i = 0; i < 4; i++)
         read_check("io_scratch", io_addr(io_reg_e'(i)), scratch_shadow[i]);
      // read-only offsets, counted but otherwise ignored
      for (int i = 4; i < 8; i++)
      begin
         bus_access(io_addr(io_reg_e'(i)), 1'b1, 32'hdead_beef);
         io_writes++;
      end
      read_check("io_id", io_addr(IO_ID), 32'hc0de_0001);
      read_check("io_reserved6", io_addr(IO_RSVD6), '0);
      read_check("io_reserved7", io_addr(IO_RSVD7), '0);
      read_check("io_write_count", io_addr(IO_WRITE_COUNT), io_writes);

      for (int i = 0; i < 2; i++)
      begin
         addr = (i == 0) ? 22'o15000000 : io_base + 22'd8;
         bus_access(addr, 1'b0, '0);
         check_value("undecoded_latency", `XBUS_TIMEOUT + 1, latency);
         check_value("undecoded_error", 1, 32'(rsp_error));
         check_value("undecoded_data", '1, rdata);
      end

      $display("TEST PASS");
      $finish;
   end

endmodule

// ==== xbus_subsystem.f ====
+incdir+verilog
verilog/xbus_pkg.sv
verilog/xbus_map_pkg.sv
verilog/xbus_ram.sv
verilog/xbus_io_regs.sv
verilog/xbus_response_mux.sv
verilog/xbus_subsystem.sv
tests/xbus_subsystem_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the xbus testbench with Verilator, run it, then search the log for failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module xbus_subsystem_tb -f xbus_subsystem.f -o xbus_sim \
   > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/xbus_sim > sim.log 2>&1
cat sim.log

! grep -q "TEST FAIL" sim.log && echo "simulation passed" \
   || { echo "simulation failed, see sim.log"; exit 1; }
